// File: verilog/exec_pkg.sv
package exec_pkg;

    // Datapath width
    localparam int XLEN = 32;

    // One quotient bit per divider iteration
    localparam int DIV_STEPS = 32;
    localparam int DIV_CNT_W = $clog2(DIV_STEPS + 1);

    // Execute operations, MDU class starts at MUL
    typedef enum logic [4:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,
        SLTU,
        SLL,
        SRL,
        SRA,
        MUL,
        MULH,
        MULHSU,
        MULHU,
        DIV,
        DIVU,
        REM,
        REMU
    } alu_op_t;

    // True for operations handled by the multiply/divide unit
    function automatic logic is_mdu_op(input alu_op_t op);
        return (op >= MUL);
    endfunction

endpackage

// File: verilog/mdu_if.sv
`timescale 1ns/1ns

interface mdu_if;
    import exec_pkg::*;

    // Request side
    logic            req_valid;
    alu_op_t         op;
    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;

    // Response side, result held until acknowledged
    logic            res_valid;
    logic [XLEN-1:0] result;
    logic            res_ack;

    modport requester (
        output req_valid, op, src1, src2, res_ack,
        input  res_valid, result
    );

    modport responder (
        input  req_valid, op, src1, src2, res_ack,
        output res_valid, result
    );
endinterface

// File: verilog/alu.sv
`timescale 1ns/1ns

module alu (
    input  exec_pkg::alu_op_t           i_op,
    input  logic [exec_pkg::XLEN-1:0]   i_src1,
    input  logic [exec_pkg::XLEN-1:0]   i_src2,
    output logic [exec_pkg::XLEN-1:0]   o_result,
    output logic                        o_zero,
    output logic                        o_last_bit
);
    import exec_pkg::*;

    logic [4:0] shamt;

    // RV32I shifts only use the low five bits
    assign shamt = i_src2[4:0];

    always_comb begin
        case (i_op)
            ADD: begin
                o_result = i_src1 + i_src2;
            end
            SUB: begin
                o_result = i_src1 - i_src2;
            end
            AND: begin
                o_result = i_src1 & i_src2;
            end
            OR: begin
                o_result = i_src1 | i_src2;
            end
            XOR: begin
                o_result = i_src1 ^ i_src2;
            end
            SLT: begin
                o_result = XLEN'($signed(i_src1) < $signed(i_src2));
            end
            SLTU: begin
                o_result = XLEN'(i_src1 < i_src2);
            end
            SLL: begin
                o_result = i_src1 << shamt;
            end
            SRL: begin
                o_result = i_src1 >> shamt;
            end
            SRA: begin
                o_result = $signed(i_src1) >>> shamt;
            end
            // MDU class results come from the multiply/divide unit
            default: begin
                o_result = '0;
            end
        endcase
    end

    // Flags used by branch decisions
    assign o_zero     = (o_result == '0);
    assign o_last_bit = o_result[0];

endmodule

// File: verilog/mul_div_unit.sv
`timescale 1ns/1ns

module mul_div_unit (
    input logic      clk,
    input logic      rst_n,
    mdu_if.responder mdu
);
    import exec_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_DIV,
        S_DONE
    } state_t;

    state_t               state;
    logic [DIV_CNT_W-1:0] count;

    // Divider datapath and captured request
    logic [XLEN-1:0] rem_q;
    logic [XLEN-1:0] quo_q;
    logic [XLEN-1:0] divisor_q;
    logic [XLEN-1:0] dividend_q;
    logic            q_neg_q;
    logic            r_neg_q;
    logic            div_zero_q;
    logic            want_rem_q;
    logic [XLEN-1:0] result_q;

    logic                     start;
    logic                     is_div_op;
    logic                     signed_div;
    logic                     s1_neg;
    logic                     s2_neg;
    logic [XLEN-1:0]          src1_mag;
    logic [XLEN-1:0]          src2_mag;
    logic                     a_signed;
    logic                     b_signed;
    logic signed [XLEN:0]     mul_a;
    logic signed [XLEN:0]     mul_b;
    logic signed [2*XLEN+1:0] product;
    logic [XLEN-1:0]          mul_result;
    logic [XLEN:0]            shifted;
    logic [XLEN:0]            diff;
    logic [XLEN-1:0]          rem_next;
    logic [XLEN-1:0]          quo_next;
    logic [XLEN-1:0]          quo_fixed;
    logic [XLEN-1:0]          rem_fixed;

    assign start = (state == S_IDLE) && mdu.req_valid;

    // Operand decoding for both datapaths
    always_comb begin
        is_div_op  = (mdu.op == DIV) || (mdu.op == DIVU) ||
                     (mdu.op == REM) || (mdu.op == REMU);
        signed_div = (mdu.op == DIV) || (mdu.op == REM);
        s1_neg     = signed_div && mdu.src1[XLEN-1];
        s2_neg     = signed_div && mdu.src2[XLEN-1];
        src1_mag   = s1_neg ? -mdu.src1 : mdu.src1;
        src2_mag   = s2_neg ? -mdu.src2 : mdu.src2;

        // 33x33 signed product covers all four multiply flavours
        a_signed   = (mdu.op == MULH) || (mdu.op == MULHSU);
        b_signed   = (mdu.op == MULH);
        mul_a      = {a_signed && mdu.src1[XLEN-1], mdu.src1};
        mul_b      = {b_signed && mdu.src2[XLEN-1], mdu.src2};
        product    = mul_a * mul_b;
        mul_result = (mdu.op == MUL) ? product[XLEN-1:0] : product[2*XLEN-1:XLEN];
    end

    // One restoring step, dividend bits shift in from the quotient register
    always_comb begin
        shifted   = {rem_q, quo_q[XLEN-1]};
        diff      = shifted - {1'b0, divisor_q};
        rem_next  = diff[XLEN] ? shifted[XLEN-1:0] : diff[XLEN-1:0];
        quo_next  = {quo_q[XLEN-2:0], !diff[XLEN]};
        quo_fixed = q_neg_q ? -quo_next : quo_next;
        rem_fixed = r_neg_q ? -rem_next : rem_next;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= S_IDLE;
            count <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (mdu.req_valid) begin
                        state <= is_div_op ? S_DIV : S_DONE;
                        count <= DIV_CNT_W'(DIV_STEPS - 1);
                    end
                end
                S_DIV: begin
                    // Sign fix-up rides along with the last step
                    if (count == '0) begin
                        state <= S_DONE;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                S_DONE: begin
                    if (mdu.res_ack) begin
                        state <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            result_q   <= mul_result;
            rem_q      <= '0;
            quo_q      <= src1_mag;
            divisor_q  <= src2_mag;
            dividend_q <= mdu.src1;
            q_neg_q    <= s1_neg ^ s2_neg;
            r_neg_q    <= s1_neg;
            div_zero_q <= (mdu.src2 == '0);
            want_rem_q <= (mdu.op == REM) || (mdu.op == REMU);
        end else if (state == S_DIV) begin
            rem_q <= rem_next;
            quo_q <= quo_next;
            if (count == '0) begin
                // Divide by zero per RV32M, overflow falls out of the magnitudes
                if (div_zero_q) begin
                    result_q <= want_rem_q ? dividend_q : '1;
                end else begin
                    result_q <= want_rem_q ? rem_fixed : quo_fixed;
                end
            end
        end
    end

    assign mdu.res_valid = (state == S_DONE);
    assign mdu.result    = result_q;

endmodule

// File: verilog/exec_result_select.sv
`timescale 1ns/1ns

module exec_result_select (
    input  logic                        i_valid,
    input  exec_pkg::alu_op_t           i_op,
    input  logic [exec_pkg::XLEN-1:0]   i_src1,
    input  logic [exec_pkg::XLEN-1:0]   i_src2,
    input  logic                        i_hold,
    input  logic [exec_pkg::XLEN-1:0]   i_alu_result,
    mdu_if.requester                    mdu,
    output logic [exec_pkg::XLEN-1:0]   o_result,
    output logic                        o_stall
);
    import exec_pkg::*;

    logic mdu_class;

    assign mdu_class = is_mdu_op(i_op);

    // Request side, operands held stable by the stall
    assign mdu.req_valid = i_valid && mdu_class;
    assign mdu.op        = i_op;
    assign mdu.src1      = i_src1;
    assign mdu.src2      = i_src2;

    // Upstream hold keeps the result parked in the MDU
    assign mdu.res_ack = mdu.res_valid && !i_hold;

    // Held until the result is actually taken
    assign o_stall = mdu.req_valid && !mdu.res_ack;

    assign o_result = mdu_class ? mdu.result : i_alu_result;

endmodule

// File: verilog/exec_unit.sv
`timescale 1ns/1ns

module exec_unit (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        i_valid,
    input  exec_pkg::alu_op_t           i_op,
    input  logic [exec_pkg::XLEN-1:0]   i_src1,
    input  logic [exec_pkg::XLEN-1:0]   i_src2,
    input  logic                        i_hold,
    output logic [exec_pkg::XLEN-1:0]   o_result,
    output logic                        o_zero,
    output logic                        o_last_bit,
    output logic                        o_stall
);
    import exec_pkg::*;

    logic [XLEN-1:0] alu_result;

    mdu_if mdu_bus ();

    // Single cycle base integer operations
    alu alu0 (
        .i_op       (i_op),
        .i_src1     (i_src1),
        .i_src2     (i_src2),
        .o_result   (alu_result),
        .o_zero     (o_zero),
        .o_last_bit (o_last_bit)
    );

    // Multi cycle multiply and divide
    mul_div_unit mdu0 (
        .clk   (clk),
        .rst_n (rst_n),
        .mdu   (mdu_bus.responder)
    );

    // Request issue, stall and result mux
    exec_result_select sel0 (
        .i_valid      (i_valid),
        .i_op         (i_op),
        .i_src1       (i_src1),
        .i_src2       (i_src2),
        .i_hold       (i_hold),
        .i_alu_result (alu_result),
        .mdu          (mdu_bus.requester),
        .o_result     (o_result),
        .o_stall      (o_stall)
    );

endmodule

// File: tests/exec_unit_assert.sv
`timescale 1ns/1ns

module exec_unit_assert (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      i_valid,
    input exec_pkg::alu_op_t         i_op,
    input logic [exec_pkg::XLEN-1:0] i_src1,
    input logic [exec_pkg::XLEN-1:0] i_src2,
    input logic                      i_hold,
    input logic [exec_pkg::XLEN-1:0] o_result,
    input logic                      o_zero,
    input logic                      o_last_bit,
    input logic                      o_stall
);
    import exec_pkg::*;

    int unsigned     stall_cycles;
    int unsigned     held;
    int unsigned     due;
    int              fails = 0;
    logic            mdu_op;
    logic [XLEN-1:0] expect_val;

    // Reference results from the RV32IM rules
    function automatic logic [XLEN-1:0] model(input alu_op_t op, input logic [XLEN-1:0] a,
                                              input logic [XLEN-1:0] b);
        logic signed [2*XLEN-1:0] sa;
        logic signed [2*XLEN-1:0] sb;
        logic [2*XLEN-1:0]        p_ss;
        logic [2*XLEN-1:0]        p_su;
        logic [2*XLEN-1:0]        p_uu;
        logic [XLEN-1:0]          q_s;
        logic [XLEN-1:0]          r_s;
        logic [XLEN-1:0]          r;
        sa   = {{XLEN{a[XLEN-1]}}, a};
        sb   = {{XLEN{b[XLEN-1]}}, b};
        p_ss = {{XLEN{a[XLEN-1]}}, a} * {{XLEN{b[XLEN-1]}}, b};
        p_su = {{XLEN{a[XLEN-1]}}, a} * {{XLEN{1'b0}}, b};
        p_uu = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
        // At double width the most negative value over -1 needs no special case
        q_s  = XLEN'(sa / sb);
        r_s  = XLEN'(sa % sb);
        case (op)
            ADD:     r = a + b;
            SUB:     r = a - b;
            AND:     r = a & b;
            OR:      r = a | b;
            XOR:     r = a ^ b;
            SLT:     r = XLEN'(sa < sb);
            SLTU:    r = XLEN'(a < b);
            SLL:     r = a << b[4:0];
            SRL:     r = a >> b[4:0];
            SRA:     r = XLEN'(sa >> b[4:0]);
            MUL:     r = p_uu[XLEN-1:0];
            MULH:    r = p_ss[2*XLEN-1:XLEN];
            MULHSU:  r = p_su[2*XLEN-1:XLEN];
            MULHU:   r = p_uu[2*XLEN-1:XLEN];
            DIV:     r = (b == '0) ? '1 : q_s;
            DIVU:    r = (b == '0) ? '1 : a / b;
            REM:     r = (b == '0) ? a : r_s;
            REMU:    r = (b == '0) ? a : a % b;
            default: r = '0;
        endcase
        return r;
    endfunction

    assign mdu_op     = is_mdu_op(i_op);
    assign expect_val = model(i_op, i_src1, i_src2);
    assign due        = (i_op >= DIV) ? DIV_STEPS + 1 : 1;

    // Stall length so far, and hold cycles after the result was due
    always_ff @(posedge clk) begin
        if (!rst_n || !o_stall) begin
            stall_cycles <= 0;
            held         <= 0;
        end else begin
            stall_cycles <= stall_cycles + 1;
            if (i_hold && stall_cycles >= due) begin
                held <= held + 1;
            end
        end
    end

    a_alu: assert property (@(posedge clk) disable iff (!rst_n) i_valid && !mdu_op |->
            o_result == expect_val && o_zero == (expect_val == '0) &&
            o_last_bit == expect_val[0] && !o_stall)
        else begin
            $error("[FAIL] o_result %h o_zero %h o_last_bit %h o_stall %h expected %h %h %h 0",
                   o_result, o_zero, o_last_bit, o_stall,
                   expect_val, expect_val == '0, expect_val[0]);
            fails++;
        end

    a_mdu: assert property (@(posedge clk) disable iff (!rst_n) i_valid && mdu_op && !o_stall
            |-> o_result == expect_val)
        else begin
            $error("[FAIL] o_result %h expected %h", o_result, expect_val);
            fails++;
        end

    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
            i_valid && mdu_op && !o_stall |-> stall_cycles == due + held)
        else begin
            $error("stall lasted %0d cycles instead of %0d", stall_cycles, due + held);
            fails++;
        end

    a_parked: assert property (@(posedge clk) disable iff (!rst_n)
            o_stall && stall_cycles > due |-> $stable(o_result))
        else begin
            $error("result changed while held back by i_hold");
            fails++;
        end

endmodule

// File: tests/tb_exec_unit.sv
`timescale 1ns/1ns

module tb_exec_unit;
    import exec_pkg::*;

    localparam int MAX_HOLD = 8;
    // Idle 1, ALU 30, multiply 24, divide 24, hold 8
    localparam int NUM_OPS  = 87;
    localparam int LIMIT    = NUM_OPS * (DIV_STEPS + 2 + MAX_HOLD) + 100;

    logic            clk;
    logic            rst_n;
    logic            i_valid;
    alu_op_t         i_op;
    logic [XLEN-1:0] i_src1;
    logic [XLEN-1:0] i_src2;
    logic            i_hold;
    logic [XLEN-1:0] o_result;
    logic            o_zero;
    logic            o_last_bit;
    logic            o_stall;

    logic [31:0]     lfsr = 32'h8bb3b4b5;
    int              cycles = 0;
    int              fails_before = 0;
    int              tests_ok = 0;
    int              tests_bad = 0;

    // Extremes, including divide by zero and signed overflow
    logic [XLEN-1:0] edge_a [4] = '{32'h8000_0000, 32'h8000_0000, 32'hffff_ffff, 32'h7fff_ffff};
    logic [XLEN-1:0] edge_b [4] = '{32'hffff_ffff, 32'h0000_0000, 32'hffff_ffff, 32'h8000_0000};

    exec_unit dut0 (.*);

    bind exec_unit exec_unit_assert chk0 (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > LIMIT) begin
            $display("Timeout: run exceeded %0d cycles, stall never cleared", LIMIT);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // Galois LFSR, one step per random bit
    function automatic logic next_bit();
        lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
        return lfsr[0];
    endfunction

    function automatic logic [XLEN-1:0] rand_bits(input int n);
        logic [XLEN-1:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[XLEN-2:0], next_bit()};
        end
        return v;
    endfunction

    // Starts on a rising edge, returns on the edge that ends the acknowledge cycle
    task automatic apply_op(input alu_op_t op, input logic [XLEN-1:0] a,
                            input logic [XLEN-1:0] b, input int hold_len);
        int n;
        n = 0;
        i_valid <= 1'b1;
        i_op    <= op;
        i_src1  <= a;
        i_src2  <= b;
        i_hold  <= (hold_len > 0);
        @(negedge clk);
        while (o_stall) begin
            @(posedge clk);
            n++;
            i_hold <= (n < hold_len);
            @(negedge clk);
        end
        @(posedge clk);
        i_hold <= 1'b0;
    endtask

    task automatic mdu_sweep(input alu_op_t first, input alu_op_t last);
        for (int o = first; o <= last; o++) begin
            for (int k = 0; k < 6; k++) begin
                if (k < 4) begin
                    apply_op(alu_op_t'(o), edge_a[k], edge_b[k], 0);
                end else begin
                    apply_op(alu_op_t'(o), rand_bits(XLEN), rand_bits(XLEN), 0);
                end
            end
        end
    endtask

    task automatic end_test(input string name);
        int n;
        i_valid <= 1'b0;
        @(negedge clk);
        n = dut0.chk0.fails - fails_before;
        fails_before = dut0.chk0.fails;
        if (n == 0) begin
            tests_ok++;
        end else begin
            tests_bad++;
        end
        $display("test %s: %0d assertion failures", name, n);
        @(posedge clk);
    endtask

    initial begin
        alu_op_t op;
        int      due;
        rst_n   = 1'b0;
        i_valid = 1'b0;
        i_op    = ADD;
        i_src1  = '0;
        i_src2  = '0;
        i_hold  = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        repeat (3) @(posedge clk);
        // A one cycle multiply shows the MDU left reset idle
        apply_op(MUL, rand_bits(XLEN), rand_bits(XLEN), 0);
        end_test("idle_after_reset");
        for (int r = 0; r < 3; r++) begin
            for (int o = ADD; o <= SRA; o++) begin
                apply_op(alu_op_t'(o), rand_bits(XLEN), rand_bits(XLEN), 0);
            end
        end
        end_test("alu_ops");
        mdu_sweep(MUL, MULHU);
        end_test("multiply");
        mdu_sweep(DIV, REMU);
        end_test("divide");
        // Hold starts with the request and ends 1 to 8 cycles after the result is due
        for (int k = 0; k < 8; k++) begin
            op  = alu_op_t'(MUL + rand_bits(3));
            due = (op >= DIV) ? DIV_STEPS + 1 : 1;
            apply_op(op, rand_bits(XLEN), rand_bits(XLEN), due + 1 + int'(rand_bits(3)));
        end
        end_test("hold");
        $display("tests: %0d passed, %0d failed", tests_ok, tests_bad);
        if (tests_bad == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: build.f
verilog/exec_pkg.sv
verilog/mdu_if.sv
verilog/alu.sv
verilog/mul_div_unit.sv
verilog/exec_result_select.sv
verilog/exec_unit.sv
tests/exec_unit_assert.sv
tests/tb_exec_unit.sv

// File: Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = tb_exec_unit
FLIST = build.f
OBJ   = obj_dir
LOG   = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ)
	./$(OBJ)/V$(TOP) +verilator+error+limit+1000 > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)
